//--- all.f
verilog/cache_pkg.sv
verilog/cache_way.sv
verilog/cache_replace.sv
verilog/cache_top.sv
dv/cache_tb.sv

//--- dv/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

    localparam int RAND_REQS   = 2000;
    // reset, directed accesses with margin, random requests
    localparam int TEST_CYCLES = 3 + 60 + RAND_REQS;
    localparam int WATCHDOG_NS = TEST_CYCLES * 4 * 2;

    logic                clk;
    logic                rst_n;
    logic                req;
    logic                wr;
    cache_pkg::addr_t    addr;
    cache_pkg::word_t    wr_data;
    logic                hit;
    cache_pkg::word_t    rd_data;

    // reference model state
    logic                m_valid [2][cache_pkg::NUM_SETS];
    cache_pkg::tag_t     m_tag   [2][cache_pkg::NUM_SETS];
    cache_pkg::word_t    m_data  [2][cache_pkg::NUM_SETS];
    logic                m_lru   [cache_pkg::NUM_SETS];

    integer seed = 32'h49bfa53c;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    cache_top uut (
        .clk_i     (clk),
        .rst_n_i   (rst_n),
        .req_i     (req),
        .wr_i      (wr),
        .addr_i    (addr),
        .wr_data_i (wr_data),
        .hit_o     (hit),
        .rd_data_o (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int errs_at_start);
        tests++;
        if (errors == errs_at_start) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_at_start);
        end
    endtask

    function automatic cache_pkg::addr_t addr_of(input cache_pkg::tag_t tag,
                                                 input cache_pkg::set_t set);
        return {tag, set, 2'b00};
    endfunction

    task automatic model_clear();
        for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
            m_lru[s] = 1'b0;
        end
    endtask

    // tag is address bits 31:5, set is bits 4:2
    task automatic model_lookup(input cache_pkg::addr_t a, output logic exp_hit,
                                output cache_pkg::word_t exp_data);
        cache_pkg::tag_t tag;
        cache_pkg::set_t set;
        tag = a[31:5];
        set = a[4:2];
        exp_hit = 1'b0;
        exp_data = '0;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[w][set] && m_tag[w][set] == tag) begin
                exp_hit = 1'b1;
                exp_data = m_data[w][set];
            end
        end
    endtask

    task automatic model_commit(input logic rq, input logic we, input cache_pkg::addr_t a,
                                input cache_pkg::word_t d);
        cache_pkg::tag_t tag;
        cache_pkg::set_t set;
        logic            hit0;
        logic            hit1;
        logic            victim;
        tag = a[31:5];
        set = a[4:2];
        hit0 = m_valid[0][set] && (m_tag[0][set] == tag);
        hit1 = m_valid[1][set] && (m_tag[1][set] == tag);
        if (rq && (hit0 || hit1)) begin
            // hit way becomes most recently used
            m_lru[set] = hit0 ? 1'b1 : 1'b0;
            if (we && hit0) begin
                m_data[0][set] = d;
            end else if (we) begin
                m_data[1][set] = d;
            end
        end else if (rq && we) begin
            if (!m_valid[0][set]) begin
                victim = 1'b0;
            end else if (!m_valid[1][set]) begin
                victim = 1'b1;
            end else begin
                victim = m_lru[set];
            end
            m_valid[victim][set] = 1'b1;
            m_tag[victim][set] = tag;
            m_data[victim][set] = d;
            m_lru[set] = ~victim;
        end
    endtask

    // one cycle, checked against the model just before the rising edge
    task automatic access(input logic rq, input logic we, input cache_pkg::addr_t a,
                          input cache_pkg::word_t d);
        logic             exp_hit;
        cache_pkg::word_t exp_data;
        @(negedge clk);
        req = rq;
        wr = we;
        addr = a;
        wr_data = d;
        #1;
        model_lookup(a, exp_hit, exp_data);
        check_val("hit_o", 32'(hit), 32'(exp_hit));
        check_val("rd_data_o", rd_data, exp_data);
        model_commit(rq, we, a, d);
    endtask

    // plain lookup with explicit expected values
    task automatic expect_lookup(input cache_pkg::addr_t a, input logic exp_hit,
                                 input cache_pkg::word_t exp_data);
        @(negedge clk);
        req = 1'b0;
        wr = 1'b0;
        addr = a;
        wr_data = '0;
        #1;
        check_val("hit_o", 32'(hit), 32'(exp_hit));
        check_val("rd_data_o", rd_data, exp_data);
    endtask

    initial begin
        cache_pkg::tag_t tag_pool [4];
        logic [31:0]     r;
        int              errs;
        rst_n = 1'b0;
        req = 1'b0;
        wr = 1'b0;
        addr = '0;
        wr_data = '0;
        model_clear();
        tag_pool[0] = 27'h0000a11;
        tag_pool[1] = 27'h5a5a5a5;
        tag_pool[2] = 27'h7ffffff;
        tag_pool[3] = 27'h0123456;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = errors;
        for (int s = 0; s < cache_pkg::NUM_SETS; s++) begin
            expect_lookup(addr_of(tag_pool[0], 3'(s)), 1'b0, '0);
            expect_lookup(addr_of(27'(s * 27'h13579) ^ 27'h2468ace, 3'(s)), 1'b0, '0);
        end
        end_test("reset", errs);

        errs = errors;
        access(1'b1, 1'b1, addr_of(tag_pool[0], 3'd1), 32'hcafe0001);
        expect_lookup(addr_of(tag_pool[0], 3'd1), 1'b1, 32'hcafe0001);
        expect_lookup(addr_of(tag_pool[0], 3'd2), 1'b0, '0);
        expect_lookup(addr_of(tag_pool[1], 3'd1), 1'b0, '0);
        end_test("fill_hit", errs);

        errs = errors;
        access(1'b1, 1'b1, addr_of(tag_pool[0], 3'd2), 32'h11112222);
        access(1'b1, 1'b1, addr_of(tag_pool[1], 3'd2), 32'h33334444);
        expect_lookup(addr_of(tag_pool[0], 3'd2), 1'b1, 32'h11112222);
        expect_lookup(addr_of(tag_pool[1], 3'd2), 1'b1, 32'h33334444);
        end_test("both_ways", errs);

        // A and B fill set 3, a read of A leaves B as the victim for C
        errs = errors;
        access(1'b1, 1'b1, addr_of(tag_pool[0], 3'd3), 32'haaaa0000);
        access(1'b1, 1'b1, addr_of(tag_pool[1], 3'd3), 32'hbbbb0000);
        access(1'b1, 1'b0, addr_of(tag_pool[0], 3'd3), '0);
        access(1'b1, 1'b1, addr_of(tag_pool[2], 3'd3), 32'hcccc0000);
        expect_lookup(addr_of(tag_pool[0], 3'd3), 1'b1, 32'haaaa0000);
        expect_lookup(addr_of(tag_pool[2], 3'd3), 1'b1, 32'hcccc0000);
        expect_lookup(addr_of(tag_pool[1], 3'd3), 1'b0, '0);
        end_test("lru_evict", errs);

        // B sits in way 1 while the victim is way 0, a fill would lose A
        errs = errors;
        access(1'b1, 1'b1, addr_of(tag_pool[0], 3'd4), 32'h01010101);
        access(1'b1, 1'b1, addr_of(tag_pool[1], 3'd4), 32'h02020202);
        access(1'b1, 1'b1, addr_of(tag_pool[1], 3'd4), 32'h03030303);
        expect_lookup(addr_of(tag_pool[1], 3'd4), 1'b1, 32'h03030303);
        expect_lookup(addr_of(tag_pool[0], 3'd4), 1'b1, 32'h01010101);
        end_test("write_hit", errs);

        // four tags over two ways keep evictions frequent
        errs = errors;
        for (int i = 0; i < RAND_REQS; i++) begin
            r = $random(seed);
            access(1'b1, r[10], {tag_pool[r[1:0]], r[4:2], r[6:5]}, $random(seed));
        end
        @(negedge clk);
        req = 1'b0;
        end_test("random_mix", errs);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cache_tb -f all.f -o cache_sim

out=$(./obj_dir/cache_sim)
echo "$out"

if echo "$out" | grep -qF "=== PASS ==="; then
    exit 0
fi
exit 1

//--- verilog/cache_pkg.sv
package cache_pkg;

    // address and data widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;

    // address split, byte offset at the bottom
    localparam int OFFSET_W = 2;
    localparam int SET_W    = 3;
    localparam int TAG_W    = ADDR_W - SET_W - OFFSET_W;

    // one entry per set index value
    localparam int NUM_SETS = 1 << SET_W;

    // byte address as seen on the port
    typedef logic [ADDR_W-1:0] addr_t;

    // one stored data word
    typedef logic [WORD_W-1:0] word_t;

    // upper address bits kept beside each word
    typedef logic [TAG_W-1:0] tag_t;

    // selects one of NUM_SETS entries in every way
    typedef logic [SET_W-1:0] set_t;

    // lookup result of one way for the addressed set
    // hit is only ever high together with valid
    typedef struct packed {
        logic  hit;
        logic  valid;
        word_t data;
    } way_result_t;

endpackage

//--- verilog/cache_replace.sv
`timescale 1ns/1ps

module cache_replace (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  cache_pkg::set_t        set_i,
    input  logic                   req_i,
    input  logic                   wr_i,
    input  cache_pkg::way_result_t way0_i,
    input  cache_pkg::way_result_t way1_i,
    output logic                   we0_o,
    output logic                   we1_o,
    output logic                   hit_o,
    output cache_pkg::word_t       rd_data_o
);

    // one bit per set, names the way to evict next
    logic [cache_pkg::NUM_SETS-1:0] lru_q;

    logic any_hit;
    logic hit_way;
    logic cur_lru;
    logic victim;
    logic wr_hit;
    logic wr_miss;
    logic lru_upd;
    logic lru_new;

    // a tag lives in at most one way, so the hits never overlap
    assign any_hit = way0_i.hit | way1_i.hit;
    assign hit_way = way1_i.hit;

    assign hit_o = any_hit;

    // read data is zero on a miss
    always_comb begin
        if (way0_i.hit) begin
            rd_data_o = way0_i.data;
        end else if (way1_i.hit) begin
            rd_data_o = way1_i.data;
        end else begin
            rd_data_o = '0;
        end
    end

    assign cur_lru = lru_q[set_i];

    // fill empty ways first, way 0 before way 1
    always_comb begin
        if (!way0_i.valid) begin
            victim = 1'b0;
        end else if (!way1_i.valid) begin
            victim = 1'b1;
        end else begin
            victim = cur_lru;
        end
    end

    // request decode
    assign wr_hit  = req_i & wr_i & any_hit;
    assign wr_miss = req_i & wr_i & ~any_hit;

    // a write hit overwrites in place, a write miss fills the victim
    always_comb begin
        we0_o = 1'b0;
        we1_o = 1'b0;
        if (wr_hit) begin
            we0_o = ~hit_way;
            we1_o = hit_way;
        end else if (wr_miss) begin
            we0_o = ~victim;
            we1_o = victim;
        end
    end

    // read misses leave the LRU alone
    assign lru_upd = (req_i & any_hit) | wr_miss;

    // point away from the way just used
    assign lru_new = any_hit ? ~hit_way : ~victim;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            lru_q <= '0;
        end else if (lru_upd) begin
            lru_q[set_i] <= lru_new;
        end
    end

endmodule

//--- verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top (
    input  logic              clk_i,
    input  logic              rst_n_i,
    input  logic              req_i,
    input  logic              wr_i,
    input  cache_pkg::addr_t  addr_i,
    input  cache_pkg::word_t  wr_data_i,
    output logic              hit_o,
    output cache_pkg::word_t  rd_data_o
);

    // address fields, the byte offset is dropped
    cache_pkg::tag_t addr_tag;
    cache_pkg::set_t addr_set;

    assign addr_tag = addr_i[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];
    assign addr_set = addr_i[cache_pkg::OFFSET_W +: cache_pkg::SET_W];

    // way results and write enables
    cache_pkg::way_result_t res0;
    cache_pkg::way_result_t res1;
    logic                   we0;
    logic                   we1;

    cache_way way0 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .set_i     (addr_set),
        .tag_i     (addr_tag),
        .we_i      (we0),
        .wr_data_i (wr_data_i),
        .res_o     (res0)
    );

    cache_way way1 (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .set_i     (addr_set),
        .tag_i     (addr_tag),
        .we_i      (we1),
        .wr_data_i (wr_data_i),
        .res_o     (res1)
    );

    // merge, victim choice and LRU state
    cache_replace u_replace (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .set_i     (addr_set),
        .req_i     (req_i),
        .wr_i      (wr_i),
        .way0_i    (res0),
        .way1_i    (res1),
        .we0_o     (we0),
        .we1_o     (we1),
        .hit_o     (hit_o),
        .rd_data_o (rd_data_o)
    );

endmodule

//--- verilog/cache_way.sv
`timescale 1ns/1ps

module cache_way (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  cache_pkg::set_t        set_i,
    input  cache_pkg::tag_t        tag_i,
    input  logic                   we_i,
    input  cache_pkg::word_t       wr_data_i,
    output cache_pkg::way_result_t res_o
);

    // per-set storage
    logic [cache_pkg::NUM_SETS-1:0] valid_q;
    cache_pkg::tag_t                tag_q  [cache_pkg::NUM_SETS];
    cache_pkg::word_t               data_q [cache_pkg::NUM_SETS];

    // entry selected by the current address
    logic             cur_valid;
    cache_pkg::tag_t  cur_tag;
    cache_pkg::word_t cur_data;
    logic             tag_match;

    assign cur_valid = valid_q[set_i];
    assign cur_tag   = tag_q[set_i];
    assign cur_data  = data_q[set_i];

    // compare against the stored tag, no clock involved
    assign tag_match = (cur_tag == tag_i);

    always_comb begin
        res_o       = '0;
        res_o.valid = cur_valid;
        // an invalid entry never hits, whatever its tag holds
        res_o.hit   = cur_valid & tag_match;
        res_o.data  = cur_data;
    end

    // valid bits, cleared by reset
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[set_i] <= 1'b1;
        end
    end

    // tag and word written together
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[set_i]  <= tag_i;
            data_q[set_i] <= wr_data_i;
        end
    end

endmodule
